// ==== verilog/uart_pkg.sv ====
// uart shared types
package uart_pkg;

    // payload and divider field widths carried by the structs
    localparam int BYTE_WIDTH        = 8;
    localparam int CFG_DIVIDER_WIDTH = 32;

    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_ODD  = 2'd1,
        PARITY_EVEN = 2'd2
    } parity_mode_e;

    // run-time frame format, held stable while a frame is in flight
    typedef struct packed {
        logic [CFG_DIVIDER_WIDTH-1:0] divider;
        parity_mode_e                 parity;
    } uart_cfg_t;

    // ready travels separately, against the flow
    typedef struct packed {
        logic                  valid;
        logic [BYTE_WIDTH-1:0] data;
    } byte_stream_t;

    // single-cycle error strobes
    typedef struct packed {
        logic parity_err;
        logic frame_err;
        logic overrun;
    } rx_status_t;

endpackage

// ==== verilog/uart_tx.sv ====
// uart transmitter
`timescale 1ns/1ns

module uart_tx #(
    parameter int DATA_WIDTH    = 8,
    parameter int DIVIDER_WIDTH = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_pkg::uart_cfg_t    cfg_i,
    input  uart_pkg::byte_stream_t in_i,
    output logic                   ready_o,
    output logic                   tx_o
);

    localparam int BIT_CNT_WIDTH = $clog2(DATA_WIDTH);

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4
    } tx_state_e;

    tx_state_e                state;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic [DIVIDER_WIDTH-1:0] baud_cnt;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic [   DATA_WIDTH-1:0] shift_q;
    logic                     parity_q;
    logic                     accept;
    logic                     baud_done;
    logic                     last_bit;

    assign divider   = cfg_i.divider[DIVIDER_WIDTH-1:0];
    assign ready_o   = (state == IDLE);
    assign accept    = in_i.valid && ready_o;
    assign baud_done = (baud_cnt == divider - 1'b1);
    assign last_bit  = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));

    // one bit period per divider cycles
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            baud_cnt <= '0;
        end else if ((state == IDLE) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= IDLE;
            bit_cnt <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= START;
                        bit_cnt <= '0;
                        tx_o    <= 1'b0;
                    end
                end
                START: begin
                    if (baud_done) begin
                        state <= DATA;
                        tx_o  <= shift_q[0];
                    end
                end
                DATA: begin
                    if (baud_done) begin
                        if (last_bit) begin
                            bit_cnt <= '0;
                            if (cfg_i.parity == uart_pkg::PARITY_NONE) begin
                                state <= STOP;
                                tx_o  <= 1'b1;
                            end else begin
                                state <= PARITY;
                                tx_o  <= parity_q;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_o    <= shift_q[1];
                        end
                    end
                end
                PARITY: begin
                    if (baud_done) begin
                        state <= STOP;
                        tx_o  <= 1'b1;
                    end
                end
                STOP: begin
                    if (baud_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                    tx_o  <= 1'b1;
                end
            endcase
        end
    end

    // byte and its parity bit latched on accept, lsb shifted out first
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_q  <= in_i.data;
            parity_q <= (^in_i.data) ^ (cfg_i.parity == uart_pkg::PARITY_ODD);
        end else if ((state == DATA) && baud_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    // line must rest at mark level between frames
    a_idle_line_high: assert property (
        @(posedge clk_i) disable iff (rst_i) (state == IDLE) |-> tx_o
    );

endmodule

// ==== verilog/uart_rx.sv ====
// uart receiver
`timescale 1ns/1ns

module uart_rx #(
    parameter int DATA_WIDTH    = 8,
    parameter int DIVIDER_WIDTH = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_pkg::uart_cfg_t    cfg_i,
    input  logic                   rx_i,
    output uart_pkg::byte_stream_t out_o,
    output logic                   parity_err_o,
    output logic                   frame_err_o
);

    localparam int BIT_CNT_WIDTH = $clog2(DATA_WIDTH);

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4,
        WAIT   = 3'd5
    } rx_state_e;

    rx_state_e                state;
    logic                     rx_meta;
    logic                     rx_sync;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic [DIVIDER_WIDTH-1:0] half_div;
    logic [DIVIDER_WIDTH-1:0] baud_cnt;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic [   DATA_WIDTH-1:0] rx_data;
    logic [   DATA_WIDTH-1:0] out_data_q;
    logic                     out_valid_q;
    logic                     parity_ok;
    logic                     exp_parity;
    logic                     baud_done;
    logic                     start_check;
    logic                     last_bit;

    assign divider     = cfg_i.divider[DIVIDER_WIDTH-1:0];
    assign half_div    = divider >> 1;
    assign baud_done   = (baud_cnt == divider - 1'b1);
    assign start_check = (state == START) && (baud_cnt == half_div - 1'b1);
    assign last_bit    = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));
    assign exp_parity  = (^rx_data) ^ (cfg_i.parity == uart_pkg::PARITY_ODD);

    assign out_o = '{valid: out_valid_q, data: out_data_q};

    // two-flop synchronizer, idles at mark level
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    // restarts at the mid-start check so later samples land mid-bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            baud_cnt <= '0;
        end else if ((state == IDLE) || (state == WAIT) || baud_done || start_check) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state        <= IDLE;
            bit_cnt      <= '0;
            parity_ok    <= 1'b1;
            out_valid_q  <= 1'b0;
            parity_err_o <= 1'b0;
            frame_err_o  <= 1'b0;
        end else begin
            out_valid_q  <= 1'b0;
            parity_err_o <= 1'b0;
            frame_err_o  <= 1'b0;
            case (state)
                IDLE: begin
                    if (!rx_sync) begin
                        state     <= START;
                        bit_cnt   <= '0;
                        parity_ok <= 1'b1;
                    end
                end
                START: begin
                    // short low pulse is a glitch, not a start bit
                    if (start_check) begin
                        state <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (baud_done) begin
                        if (last_bit) begin
                            bit_cnt <= '0;
                            if (cfg_i.parity == uart_pkg::PARITY_NONE) begin
                                state <= STOP;
                            end else begin
                                state <= PARITY;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PARITY: begin
                    if (baud_done) begin
                        state     <= STOP;
                        parity_ok <= (rx_sync == exp_parity);
                    end
                end
                STOP: begin
                    // framing error takes priority over parity
                    if (baud_done) begin
                        state        <= WAIT;
                        out_valid_q  <= rx_sync && parity_ok;
                        parity_err_o <= rx_sync && !parity_ok;
                        frame_err_o  <= !rx_sync;
                    end
                end
                WAIT: begin
                    // hold off until the line is back at mark
                    if (rx_sync) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb arrives first, shifted in from the top
    always_ff @(posedge clk_i) begin
        if ((state == DATA) && baud_done) begin
            rx_data <= {rx_sync, rx_data[DATA_WIDTH-1:1]};
        end
        if ((state == STOP) && baud_done) begin
            out_data_q <= rx_data;
        end
    end

    a_one_outcome_per_frame: assert property (
        @(posedge clk_i) disable iff (rst_i) !(out_o.valid && (parity_err_o || frame_err_o))
    );

endmodule

// ==== verilog/uart_rx_fifo.sv ====
// receive byte fifo
`timescale 1ns/1ns

module uart_rx_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_pkg::byte_stream_t in_i,
    output uart_pkg::byte_stream_t out_o,
    input  logic                   ready_i,
    output logic                   overrun_o
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [ PTR_WIDTH-1:0] wr_ptr;
    logic [ PTR_WIDTH-1:0] rd_ptr;
    logic [   PTR_WIDTH:0] count;
    logic                  full;
    logic                  wr_en;
    logic                  rd_en;

    assign full  = (count == (PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign rd_en = out_o.valid && ready_i;
    // a read in the same cycle frees the slot
    assign wr_en = in_i.valid && (!full || rd_en);

    assign out_o = '{valid: (count != '0), data: mem[rd_ptr]};

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_i.data;
        end
    end

    // pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overrun_o <= 1'b0;
        end else begin
            overrun_o <= in_i.valid && !wr_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bounded: assert property (
        @(posedge clk_i) disable iff (rst_i) count <= (PTR_WIDTH + 1)'(FIFO_DEPTH)
    );

endmodule

// ==== verilog/uart_core.sv ====
// uart transceiver top
`timescale 1ns/1ns

module uart_core #(
    parameter int DATA_WIDTH    = 8,
    parameter int DIVIDER_WIDTH = 32,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_pkg::uart_cfg_t    cfg_i,
    input  uart_pkg::byte_stream_t tx_in_i,
    output logic                   tx_ready_o,
    output logic                   uart_tx_o,
    input  logic                   uart_rx_i,
    output uart_pkg::byte_stream_t rx_out_o,
    input  logic                   rx_ready_i,
    output uart_pkg::rx_status_t   status_o
);

    uart_pkg::byte_stream_t rx_byte;
    logic                   parity_err;
    logic                   frame_err;
    logic                   overrun;

    // stream payload field has to match the frame width
    if (DATA_WIDTH != uart_pkg::BYTE_WIDTH) begin : g_bad_data_width
        $error("DATA_WIDTH does not match the stream data field");
    end

    if (DIVIDER_WIDTH > uart_pkg::CFG_DIVIDER_WIDTH) begin : g_bad_divider_width
        $error("DIVIDER_WIDTH exceeds the cfg divider field");
    end

    if ((FIFO_DEPTH < 2) || ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)) begin : g_bad_depth
        $error("FIFO_DEPTH must be a power of two, at least 2");
    end

    uart_tx #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_WIDTH(DIVIDER_WIDTH)
    ) u_tx (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .cfg_i  (cfg_i),
        .in_i   (tx_in_i),
        .ready_o(tx_ready_o),
        .tx_o   (uart_tx_o)
    );

    uart_rx #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_WIDTH(DIVIDER_WIDTH)
    ) u_rx (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cfg_i       (cfg_i),
        .rx_i        (uart_rx_i),
        .out_o       (rx_byte),
        .parity_err_o(parity_err),
        .frame_err_o (frame_err)
    );

    uart_rx_fifo #(
        .DATA_WIDTH(DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .in_i     (rx_byte),
        .out_o    (rx_out_o),
        .ready_i  (rx_ready_i),
        .overrun_o(overrun)
    );

    assign status_o = '{parity_err: parity_err, frame_err: frame_err, overrun: overrun};

endmodule

// ==== tests/uart_tb_tasks.svh ====
// uart testbench helpers
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

    task automatic check_byte(input string name, input uart_pkg::byte_stream_t exp,
                              input uart_pkg::byte_stream_t act);
        // data only matters on a valid entry
        if ((exp.valid !== act.valid) || (exp.valid && (exp.data !== act.data))) begin
            report_failure($sformatf("mismatch %s: expected valid %b data %h, actual valid %b data %h",
                                     name, exp.valid, exp.data, act.valid, act.data));
        end
    endtask

    task automatic check_status(input string name, input uart_pkg::rx_status_t exp,
                                input uart_pkg::rx_status_t act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch %s: expected status %b, actual status %b",
                                     name, exp, act));
        end
    endtask

    task automatic hold_line(input logic level, input int cycles);
        inject_line = level;
        repeat (cycles) @(negedge clk_i);
    endtask

    // start, lsb first data, optional parity, one stop bit
    task automatic send_frame(input logic [DATA_WIDTH-1:0] data, input uart_pkg::uart_cfg_t c,
                              input logic bad_parity, input logic bad_stop);
        int   div;
        int   i;
        logic par;
        div = int'(c.divider);
        hold_line(1'b0, div);
        for (i = 0; i < DATA_WIDTH; i++) begin
            hold_line(data[i], div);
        end
        // even parity keeps the number of ones even
        par = (c.parity == uart_pkg::PARITY_EVEN) ? ^data : ~^data;
        if (c.parity != uart_pkg::PARITY_NONE) begin
            hold_line(par ^ bad_parity, div);
        end
        hold_line(!bad_stop, div);
        hold_line(1'b1, 2 * div);
    endtask

`endif

// ==== tests/tb_uart_core.sv ====
// uart core testbench
`timescale 1ns/1ns

module tb_uart_core;

    localparam int DATA_WIDTH = 8;
    localparam int FIFO_DEPTH = 4;
    localparam uart_pkg::rx_status_t PARITY_STROBE = '{parity_err: 1'b1, frame_err: 1'b0,
                                                       overrun: 1'b0};
    localparam uart_pkg::rx_status_t FRAME_STROBE = '{parity_err: 1'b0, frame_err: 1'b1,
                                                      overrun: 1'b0};
    localparam uart_pkg::rx_status_t OVERRUN_STROBE = '{parity_err: 1'b0, frame_err: 1'b0,
                                                        overrun: 1'b1};

    typedef enum logic [2:0] {
        MODE_LOOPBACK, MODE_BAD_PARITY, MODE_BAD_STOP, MODE_GLITCH, MODE_HOLD_READY
    } mode_e;

    typedef struct packed {
        uart_pkg::uart_cfg_t  cfg;
        mode_e                mode;
        int                   count;
        int                   exp_bytes;
        uart_pkg::rx_status_t strobe;
        int                   n_strobes;
    } test_t;

    logic                   clk_i;
    logic                   rst_i;
    uart_pkg::uart_cfg_t    cfg;
    uart_pkg::byte_stream_t tx_in;
    logic                   tx_ready;
    logic                   uart_tx;
    logic                   uart_rx;
    uart_pkg::byte_stream_t rx_out;
    logic                   rx_ready;
    uart_pkg::rx_status_t   status;
    logic                   loopback;
    logic                   inject_line;
    int                     rx_base;
    int                     st_base;

    test_t                  tests[$];
    string                  test_names[$];
    logic [DATA_WIDTH-1:0]  sent_q[$];
    uart_pkg::byte_stream_t rx_q[$];
    uart_pkg::rx_status_t   status_q[$];

    // rx line fed from the transmitter or from the frame task
    assign uart_rx = loopback ? uart_tx : inject_line;

    uart_core #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_WIDTH(32),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) DUT (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cfg_i     (cfg),
        .tx_in_i   (tx_in),
        .tx_ready_o(tx_ready),
        .uart_tx_o (uart_tx),
        .uart_rx_i (uart_rx),
        .rx_out_o  (rx_out),
        .rx_ready_i(rx_ready),
        .status_o  (status)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // stream transfers and strobes as seen at the rising edge
    always @(posedge clk_i) begin
        if (!rst_i && rx_out.valid && rx_ready) begin
            rx_q.push_back(rx_out);
        end
        if (!rst_i && (status != '0)) begin
            status_q.push_back(status);
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "uart_tb_tasks.svh"

    function automatic int frame_span(input uart_pkg::uart_cfg_t c);
        int bits;
        bits = DATA_WIDTH + 2;
        if (c.parity != uart_pkg::PARITY_NONE) begin
            bits = bits + 1;
        end
        return int'(c.divider) * bits;
    endfunction

    task automatic add_test(input string name, input int divider,
                            input uart_pkg::parity_mode_e parity, input mode_e mode,
                            input int count, input int exp_bytes,
                            input uart_pkg::rx_status_t strobe, input int n_strobes);
        test_t t;
        t.cfg.divider = divider;
        t.cfg.parity  = parity;
        t.mode        = mode;
        t.count       = count;
        t.exp_bytes   = exp_bytes;
        t.strobe      = strobe;
        t.n_strobes   = n_strobes;
        tests.push_back(t);
        test_names.push_back(name);
    endtask

    task automatic wait_outcomes(input int n);
        while (((rx_q.size() - rx_base) + (status_q.size() - st_base)) < n) begin
            @(negedge clk_i);
        end
    endtask

    task automatic send_byte(input string name, input logic [DATA_WIDTH-1:0] data,
                             input int span);
        int cycles;
        while (!tx_ready) begin
            @(negedge clk_i);
        end
        tx_in = '{valid: 1'b1, data: data};
        @(negedge clk_i);
        tx_in.valid = 1'b0;
        // start bit follows the accepting edge
        if (uart_tx !== 1'b0) begin
            report_failure("no start bit on the tx line after the byte was accepted");
        end
        cycles = 0;
        // ready stays low for the whole frame
        while (!tx_ready) begin
            cycles++;
            @(negedge clk_i);
        end
        if (cycles != span) begin
            report_failure($sformatf("mismatch %s: expected frame span %0d, actual %0d",
                                     name, span, cycles));
        end
    endtask

    task automatic run_test(input int idx);
        test_t                  t;
        string                  name;
        uart_pkg::byte_stream_t exp_b;
        uart_pkg::byte_stream_t act_b;
        uart_pkg::rx_status_t   exp_s;
        uart_pkg::rx_status_t   act_s;
        int                     i;
        int                     n;
        int                     got;
        t        = tests[idx];
        name     = test_names[idx];
        rx_base  = rx_q.size();
        st_base  = status_q.size();
        sent_q.delete();
        cfg      = t.cfg;
        loopback = (t.mode == MODE_LOOPBACK) || (t.mode == MODE_HOLD_READY);
        rx_ready = (t.mode != MODE_HOLD_READY);
        repeat (2) @(negedge clk_i);
        case (t.mode)
            MODE_BAD_PARITY: send_frame(8'h5a, t.cfg, 1'b1, 1'b0);
            MODE_BAD_STOP:   send_frame(8'hc3, t.cfg, 1'b0, 1'b1);
            MODE_GLITCH: begin
                // well under half a bit
                hold_line(1'b0, (t.cfg.divider < 8) ? 1 : int'(t.cfg.divider) / 4);
                // quiet for a whole frame so a false start would complete
                hold_line(1'b1, frame_span(t.cfg));
            end
            default: begin
                for (i = 0; i < t.count; i++) begin
                    sent_q.push_back(DATA_WIDTH'($urandom));
                    send_byte(name, sent_q[i], frame_span(t.cfg));
                end
            end
        endcase
        if (t.mode == MODE_HOLD_READY) begin
            wait_outcomes(t.n_strobes);
            rx_ready = 1'b1;
        end
        wait_outcomes(t.exp_bytes + t.n_strobes);
        repeat (4 * int'(t.cfg.divider)) @(negedge clk_i);
        got = rx_q.size() - rx_base;
        n   = (got > t.exp_bytes) ? got : t.exp_bytes;
        for (i = 0; i < n; i++) begin
            exp_b = '0;
            act_b = '0;
            if (i < t.exp_bytes) begin
                exp_b = '{valid: 1'b1, data: sent_q[i]};
            end
            if (i < got) begin
                act_b = rx_q[rx_base + i];
            end
            check_byte(name, exp_b, act_b);
        end
        got = status_q.size() - st_base;
        n   = (got > t.n_strobes) ? got : t.n_strobes;
        for (i = 0; i < n; i++) begin
            exp_s = (i < t.n_strobes) ? t.strobe : '0;
            act_s = (i < got) ? status_q[st_base + i] : '0;
            check_status(name, exp_s, act_s);
        end
    endtask

    initial begin
        int deadline;
        int idx;
        void'($urandom(32'hfc30f713));
        rst_i       = 1'b1;
        cfg         = '{divider: 32'd4, parity: uart_pkg::PARITY_NONE};
        tx_in       = '0;
        rx_ready    = 1'b1;
        loopback    = 1'b1;
        inject_line = 1'b1;
        rx_base     = 0;
        st_base     = 0;

        add_test("loop_div4", 4, uart_pkg::PARITY_NONE, MODE_LOOPBACK, 6, 6, '0, 0);
        add_test("loop_div7", 7, uart_pkg::PARITY_NONE, MODE_LOOPBACK, 6, 6, '0, 0);
        add_test("loop_odd", 5, uart_pkg::PARITY_ODD, MODE_LOOPBACK, 4, 4, '0, 0);
        add_test("loop_even", 6, uart_pkg::PARITY_EVEN, MODE_LOOPBACK, 4, 4, '0, 0);
        add_test("bad_parity", 8, uart_pkg::PARITY_EVEN, MODE_BAD_PARITY, 1, 0, PARITY_STROBE, 1);
        add_test("bad_stop", 8, uart_pkg::PARITY_NONE, MODE_BAD_STOP, 1, 0, FRAME_STROBE, 1);
        add_test("glitch", 8, uart_pkg::PARITY_NONE, MODE_GLITCH, 1, 0, '0, 0);
        add_test("overrun", 4, uart_pkg::PARITY_NONE, MODE_HOLD_READY, FIFO_DEPTH + 2,
                 FIFO_DEPTH, OVERRUN_STROBE, 2);

        // frames per test plus settle time, then reset and slack
        deadline = 500;
        for (idx = 0; idx < tests.size(); idx++) begin
            deadline += frame_span(tests[idx].cfg) * (tests[idx].count + 4);
        end
        fork
            begin
                repeat (deadline) @(posedge clk_i);
                report_failure("watchdog expired before all tests finished");
            end
        join_none

        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);
        if (!tx_ready || !uart_tx) begin
            report_failure("transmitter is not idle after reset");
        end
        check_byte("reset", '0, rx_out);
        check_status("reset", '0, status);

        for (idx = 0; idx < tests.size(); idx++) begin
            run_test(idx);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+tests
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_rx_fifo.sv
verilog/uart_core.sv
tests/tb_uart_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart core simulation with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_uart_core \
    -f filelist.f -o uart_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/uart_sim > sim.log 2>&1 || true
cat sim.log

grep -q "All tests passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
